// File: rtl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Tile sizes are all powers of two
`define CONV_POX        16
`define CONV_POY        4
`define CONV_POF        16
`define CONV_POX_LOG2   4
`define CONV_POY_LOG2   2
`define CONV_POF_LOG2   4

// Datapath widths
`define CONV_DIM_W      16
`define CONV_ADR_W      16
`define CONV_CHUNK_W    16
`define CONV_BASE_SHIFT 4

//////////////////////
// Instruction word fields from bit 0 upward
`define CONV_INSTR_W    64
`define CONV_OPC_W      4
`define CONV_K_W        3
`define CONV_S_W        2
`define CONV_P_W        2
`define CONV_LOG2_W     4
`define CONV_OY_W       8
`define CONV_OF_W       12
`define CONV_BASE_W     12
`define CONV_F_MODE     4
`define CONV_F_K        5
`define CONV_F_S        8
`define CONV_F_P        10
`define CONV_F_NIF      12
`define CONV_F_IX       16
`define CONV_F_OY       20
`define CONV_F_OF       28
`define CONV_F_WBASE    40
`define CONV_F_OBASE    52

`endif

// File: rtl/conv_instr_pkg.sv
`include "conv_consts.svh"

package conv_instr_pkg;

  // Only OPC_CONV starts a layer
  typedef enum logic [`CONV_OPC_W-1:0] {
    OPC_NOP  = 4'd0,
    OPC_CONV = 4'd1,
    OPC_POOL = 4'd2
  } opcode_e;

  // Raw layer instruction
  typedef logic [`CONV_INSTR_W-1:0] conv_instr_t;

  //////////////////////
  // Instruction fields
  typedef logic [`CONV_K_W-1:0] kernel_t;

  // Stride is 1 or 2
  typedef logic [`CONV_S_W-1:0] stride_t;

  typedef logic [`CONV_P_W-1:0] pad_t;

  // Log2 of a power-of-two size
  typedef logic [`CONV_LOG2_W-1:0] log2_t;

  // Base address in units of 16 words
  typedef logic [`CONV_BASE_W-1:0] base_field_t;

endpackage

// File: rtl/conv_layer_pkg.sv
`include "conv_consts.svh"

package conv_layer_pkg;

  // Sizes and counts of the layer geometry
  typedef logic [`CONV_DIM_W-1:0] dim_t;

  // Buffer and DDR word addresses
  typedef logic [`CONV_ADR_W-1:0] adr_t;

  // Chunk number within a layer
  typedef logic [`CONV_CHUNK_W-1:0] chunk_idx_t;

  //////////////////////
  // Tile sequencer FSM
  // ISSUE lasts one cycle and carries chunk_go,
  // WAIT_DONE holds until the array answers
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DONE
  } seq_state_e;

endpackage

// File: rtl/conv_ifs.sv
`timescale 1ns/1ns

// Layer parameters are held from conv_start until the next accepted instruction
interface conv_layer_if
  import conv_instr_pkg::*;
  import conv_layer_pkg::*;
();
  logic       mode;
  kernel_t    k;
  stride_t    s;
  pad_t       p;
  dim_t       nif, ix, iy, ox, oy, of;
  dim_t       nif_k_k;
  chunk_idx_t n_chunks;
  // Both bases are already scaled to word addresses
  adr_t       weights_base, out_base;
  logic       conv_start;

  modport decoder (output mode, k, s, p, nif, ix, iy, ox, oy, of,
                   nif_k_k, n_chunks, weights_base, out_base, conv_start);
  modport sequencer (input mode, k, s, p, nif, ix, iy, ox, oy, of,
                     nif_k_k, n_chunks, weights_base, out_base, conv_start);
  modport tracker (input conv_start, n_chunks, out_base);
endinterface

// One accepted array_done and the chunk it closes
interface conv_chunk_if
  import conv_layer_pkg::*;
();
  logic       done_pulse;
  chunk_idx_t chunk_idx;
  logic       last;
  // Output offset of the chunk relative to out_base
  adr_t       chunk_base;

  modport sequencer (output done_pulse, chunk_idx, last, chunk_base);
  modport tracker (input done_pulse, chunk_idx, last, chunk_base);
endinterface

// File: rtl/conv_decoder.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_decoder
  import conv_instr_pkg::*;
  import conv_layer_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  conv_instr_t   instr,
  input  logic          instr_valid,
  input  logic          busy,
  conv_layer_if.decoder lay
);

  opcode_e     opcode;
  logic        mode_f;
  kernel_t     k_f;
  stride_t     s_f;
  pad_t        p_f;
  log2_t       nif_log2, ix_log2;
  base_field_t wbase_f, obase_f;
  dim_t        oy_f, of_f;
  dim_t        ix_d, nif_d, iy_d, ox_d;
  dim_t        kk_d, nif_k_k_d;
  dim_t        ox_tiles, oy_tiles, of_tiles;
  logic        accept;

  ////////////////////
  // Field extraction
  assign opcode   = opcode_e'(instr[`CONV_OPC_W-1:0]);
  assign mode_f   = instr[`CONV_F_MODE];
  assign k_f      = instr[`CONV_F_K +: `CONV_K_W];
  assign s_f      = instr[`CONV_F_S +: `CONV_S_W];
  assign p_f      = instr[`CONV_F_P +: `CONV_P_W];
  assign nif_log2 = instr[`CONV_F_NIF +: `CONV_LOG2_W];
  assign ix_log2  = instr[`CONV_F_IX +: `CONV_LOG2_W];
  assign oy_f     = dim_t'(instr[`CONV_F_OY +: `CONV_OY_W]);
  assign of_f     = dim_t'(instr[`CONV_F_OF +: `CONV_OF_W]);
  assign wbase_f  = instr[`CONV_F_WBASE +: `CONV_BASE_W];
  assign obase_f  = instr[`CONV_F_OBASE +: `CONV_BASE_W];

  ////////////////////
  // Derived geometry
  assign ix_d  = dim_t'(1) << ix_log2;
  assign nif_d = dim_t'(1) << nif_log2;

  // Stride is 1 or 2, so the multiply and divide by s are shifts
  assign iy_d = (oy_f << (s_f - 1'b1)) + dim_t'(k_f) - dim_t'(s_f) - (dim_t'(p_f) << 1);
  assign ox_d = ((ix_d + (dim_t'(p_f) << 1) - dim_t'(k_f)) >> (s_f - 1'b1)) + dim_t'(1);

  assign kk_d      = dim_t'(k_f) * dim_t'(k_f);
  assign nif_k_k_d = kk_d << nif_log2;

  // Tiles per axis rounded up
  assign ox_tiles = (ox_d + dim_t'(`CONV_POX - 1)) >> `CONV_POX_LOG2;
  assign oy_tiles = (oy_f + dim_t'(`CONV_POY - 1)) >> `CONV_POY_LOG2;
  assign of_tiles = (of_f + dim_t'(`CONV_POF - 1)) >> `CONV_POF_LOG2;

  // Busy covers the conv_start cycle as well
  assign accept = instr_valid && (opcode == OPC_CONV) && !busy;

  always_ff @(posedge clk)
  begin
    if (reset)
      lay.conv_start <= 1'b0;
    else
      lay.conv_start <= accept;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      lay.mode         <= mode_f;
      lay.k            <= k_f;
      lay.s            <= s_f;
      lay.p            <= p_f;
      lay.nif          <= nif_d;
      lay.ix           <= ix_d;
      lay.iy           <= iy_d;
      lay.ox           <= ox_d;
      lay.oy           <= oy_f;
      lay.of           <= of_f;
      lay.nif_k_k      <= nif_k_k_d;
      lay.n_chunks     <= chunk_idx_t'(ox_tiles * oy_tiles * of_tiles);
      lay.weights_base <= adr_t'(wbase_f) << `CONV_BASE_SHIFT;
      lay.out_base     <= adr_t'(obase_f) << `CONV_BASE_SHIFT;
    end
  end

  // Sequencer busy must block the cycle right after a start
  a_start_pulse : assert property (@(posedge clk) disable iff (reset)
    lay.conv_start |=> !lay.conv_start);

endmodule

// File: rtl/conv_tile_sequencer.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_tile_sequencer
  import conv_layer_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  conv_layer_if.sequencer lay,
  input  logic            array_done,
  conv_chunk_if.sequencer chunk,
  output logic            chunk_go,
  output dim_t            ox_idx,
  output dim_t            oy_idx,
  output dim_t            of_idx,
  output adr_t            bias_adr,
  output adr_t            weights_adr,
  output logic            busy
);

  seq_state_e state;
  dim_t       ox_tiles, oy_tiles, of_tiles;
  chunk_idx_t chunk_idx;
  adr_t       chunk_base;
  logic       ox_wrap, oy_wrap, is_last, accept_done;

  assign ox_tiles = (lay.ox + dim_t'(`CONV_POX - 1)) >> `CONV_POX_LOG2;
  assign oy_tiles = (lay.oy + dim_t'(`CONV_POY - 1)) >> `CONV_POY_LOG2;
  assign of_tiles = (lay.of + dim_t'(`CONV_POF - 1)) >> `CONV_POF_LOG2;

  assign ox_wrap     = (ox_idx == dim_t'(ox_tiles - 1'b1));
  assign oy_wrap     = (oy_idx == dim_t'(oy_tiles - 1'b1));
  assign is_last     = (chunk_idx == chunk_idx_t'(lay.n_chunks - 1'b1));
  assign accept_done = (state == WAIT_DONE) && array_done;

  // Busy rises with conv_start, before the FSM leaves IDLE
  assign busy = (state != IDLE) || lay.conv_start;

  assign bias_adr = adr_t'(of_idx << `CONV_POF_LOG2);

  assign chunk.done_pulse = accept_done;
  assign chunk.chunk_idx  = chunk_idx;
  assign chunk.last       = is_last;
  assign chunk.chunk_base = chunk_base;

  ////////////////////
  // FSM walks the tiles with ox fastest, then oy, then of
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= IDLE;
      chunk_go  <= 1'b0;
      ox_idx    <= '0;
      oy_idx    <= '0;
      of_idx    <= '0;
      chunk_idx <= '0;
    end
    else
    begin
      chunk_go <= 1'b0;
      case (state)
        IDLE:
        begin
          if (lay.conv_start)
          begin
            ox_idx    <= '0;
            oy_idx    <= '0;
            of_idx    <= '0;
            chunk_idx <= '0;
            chunk_go  <= 1'b1;
            state     <= ISSUE;
          end
        end
        ISSUE:
          state <= WAIT_DONE;
        WAIT_DONE:
        begin
          if (array_done && is_last)
            state <= IDLE;
          else if (array_done)
          begin
            chunk_idx <= chunk_idx + 1'b1;
            chunk_go  <= 1'b1;
            state     <= ISSUE;
            if (!ox_wrap)
              ox_idx <= ox_idx + 1'b1;
            else
            begin
              ox_idx <= '0;
              if (!oy_wrap)
                oy_idx <= oy_idx + 1'b1;
              else
              begin
                oy_idx <= '0;
                of_idx <= of_idx + 1'b1;
              end
            end
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // One of step moves the weights address by POF filters
  always_ff @(posedge clk)
  begin
    if (state == IDLE && lay.conv_start)
    begin
      weights_adr <= lay.weights_base;
      chunk_base  <= '0;
    end
    else if (accept_done && !is_last)
    begin
      chunk_base <= chunk_base + adr_t'(`CONV_POX * `CONV_POY);
      if (ox_wrap && oy_wrap)
        weights_adr <= weights_adr + (adr_t'(lay.nif_k_k) << `CONV_POF_LOG2);
    end
  end

  a_go_state : assert property (@(posedge clk) disable iff (reset)
    state == WAIT_DONE |-> !chunk_go);

endmodule

// File: rtl/conv_writeback_tracker.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_writeback_tracker
  import conv_layer_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  conv_layer_if.tracker lay,
  conv_chunk_if.tracker chunk,
  output logic          wb_valid,
  output adr_t          wb_adr,
  output logic          layer_done
);

  adr_t       wb_next;
  chunk_idx_t done_cnt;
  logic       final_chunk;

  assign final_chunk = (done_cnt == chunk_idx_t'(lay.n_chunks - 1'b1));

  // Completion count and strobes
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_valid   <= 1'b0;
      layer_done <= 1'b0;
      done_cnt   <= '0;
    end
    else
    begin
      wb_valid   <= chunk.done_pulse;
      layer_done <= chunk.done_pulse && final_chunk;
      if (lay.conv_start)
        done_cnt <= '0;
      else if (chunk.done_pulse)
        done_cnt <= done_cnt + 1'b1;
    end
  end

  // Each chunk fills POX*POY output words
  always_ff @(posedge clk)
  begin
    if (lay.conv_start)
      wb_next <= lay.out_base;
    else if (chunk.done_pulse)
    begin
      wb_adr  <= wb_next;
      wb_next <= wb_next + adr_t'(`CONV_POX * `CONV_POY);
    end
  end

  a_last_count : assert property (@(posedge clk) disable iff (reset)
    chunk.done_pulse && chunk.last |-> final_chunk);

  // Sequencer and tracker agree on which chunk closed and where it lands
  a_chunk_order : assert property (@(posedge clk) disable iff (reset)
    chunk.done_pulse |->
      (done_cnt == chunk.chunk_idx) && (wb_next == lay.out_base + chunk.chunk_base));

endmodule

// File: rtl/conv_ctrl_top.sv
`timescale 1ns/1ns

module conv_ctrl_top
  import conv_instr_pkg::*;
  import conv_layer_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  conv_instr_t instr,
  input  logic        instr_valid,
  input  logic        array_done,
  output logic        conv_start,
  output logic        busy,
  output logic        chunk_go,
  output dim_t        ox_idx,
  output dim_t        oy_idx,
  output dim_t        of_idx,
  output adr_t        bias_adr,
  output adr_t        weights_adr,
  output logic        wb_valid,
  output adr_t        wb_adr,
  output logic        layer_done,
  output logic        mode
);

  conv_layer_if lay ();
  conv_chunk_if chunk ();

  assign conv_start = lay.conv_start;
  assign mode       = lay.mode;

  conv_decoder decoder_i (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .busy        (busy),
    .lay         (lay.decoder)
  );

  conv_tile_sequencer sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .lay         (lay.sequencer),
    .array_done  (array_done),
    .chunk       (chunk.sequencer),
    .chunk_go    (chunk_go),
    .ox_idx      (ox_idx),
    .oy_idx      (oy_idx),
    .of_idx      (of_idx),
    .bias_adr    (bias_adr),
    .weights_adr (weights_adr),
    .busy        (busy)
  );

  conv_writeback_tracker tracker_i (
    .clk        (clk),
    .reset      (reset),
    .lay        (lay.tracker),
    .chunk      (chunk.tracker),
    .wb_valid   (wb_valid),
    .wb_adr     (wb_adr),
    .layer_done (layer_done)
  );

endmodule

// File: tb/conv_ctrl_tb.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_ctrl_tb
  import conv_instr_pkg::*;
  import conv_layer_pkg::*;
();

  logic        clk, reset, instr_valid, array_done;
  conv_instr_t instr;
  logic        conv_start, busy, chunk_go, wb_valid, layer_done, mode;
  dim_t        ox_idx, oy_idx, of_idx;
  adr_t        bias_adr, weights_adr, wb_adr;

  integer seed = 24;
  int     errors = 0;
  int     timeouts = 0;
  int     layers = 0;
  int     starts = 0;

  // Fields of the layer being strobed
  int f_mode, f_k, f_s, f_p, f_nif_log2, f_ix_log2, f_oy, f_of, f_wbase, f_obase;

  // Reference model state latched at conv_start
  int exp_ox_t, exp_oy_t, exp_of_t, exp_chunks, exp_nkk, exp_mode;
  int exp_wadr, exp_oadr;
  int exp_ox, exp_oy, exp_of, go_cnt, wb_cnt;

  conv_ctrl_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .array_done  (array_done),
    .conv_start  (conv_start),
    .busy        (busy),
    .chunk_go    (chunk_go),
    .ox_idx      (ox_idx),
    .oy_idx      (oy_idx),
    .of_idx      (of_idx),
    .bias_adr    (bias_adr),
    .weights_adr (weights_adr),
    .wb_valid    (wb_valid),
    .wb_adr      (wb_adr),
    .layer_done  (layer_done),
    .mode        (mode)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Helpers
  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
  endtask

  task automatic finish_run();
    $display("Errors: %0d, timeouts: %0d, layers run: %0d, starts seen: %0d",
             errors, timeouts, layers, starts);
    if (errors == 0 && timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic int ceil_div(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  // ox = ((ix + 2p - k) >> (s-1)) + 1
  function automatic int ref_ox(input int il, input int k, input int s, input int p);
    return (((1 << il) + 2 * p - k) >> (s - 1)) + 1;
  endfunction

  // Fields from bit 0 upward are opcode, mode, k, s, p, nif_log2, ix_log2, oy, of, wbase, obase
  function automatic conv_instr_t build_instr(input opcode_e opc, input int md, k, s, p,
                                              nl, il, oy, of_n, wb, ob);
    return {ob[11:0], wb[11:0], of_n[11:0], oy[7:0], il[3:0], nl[3:0],
            p[1:0], s[1:0], k[2:0], md[0], opc};
  endfunction

  ////////////////////
  // Stimulus tasks are entered just after a falling edge
  task automatic strobe(input conv_instr_t word);
    instr = word;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    instr = '0;
  endtask

  task automatic wait_layer_done();
    int cycles;
    cycles = 0;
    while (!layer_done && cycles < 3000)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!layer_done)
    begin
      $display("Timeout: layer_done did not arrive within %0d cycles", cycles);
      timeouts++;
    end
    @(negedge clk);
  endtask

  task automatic run_layer(input int md, k, s, p, nl, il, oy, of_n, wb, ob);
    f_mode = md;
    f_k = k;
    f_s = s;
    f_p = p;
    f_nif_log2 = nl;
    f_ix_log2 = il;
    f_oy = oy;
    f_of = of_n;
    f_wbase = wb;
    f_obase = ob;
    strobe(build_instr(OPC_CONV, md, k, s, p, nl, il, oy, of_n, wb, ob));
    wait_layer_done();
    layers++;
  endtask

  task automatic random_layer();
    int k, s, p;
    k = (rand_range(0, 1) == 1) ? 3 : 1;
    s = rand_range(1, 2);
    p = rand_range(0, 1);
    run_layer(rand_range(0, 1), k, s, p, rand_range(0, 3), rand_range(2, 6),
              rand_range(1, 12), rand_range(1, 40), rand_range(0, 4095), rand_range(0, 4095));
  endtask

  // A second CONV strobed mid-layer must leave the running layer alone
  task automatic busy_strobe_test();
    int cycles, seen, starts_before;
    cycles = 0;
    seen = 0;
    starts_before = starts;
    f_mode = 1;
    f_k = 3;
    f_s = 1;
    f_p = 1;
    f_nif_log2 = 1;
    f_ix_log2 = 6;
    f_oy = 8;
    f_of = 40;
    f_wbase = 'h123;
    f_obase = 'h456;
    strobe(build_instr(OPC_CONV, 1, 3, 1, 1, 1, 6, 8, 40, 'h123, 'h456));
    while (seen < 2 && cycles < 100)
    begin
      @(negedge clk);
      cycles++;
      if (chunk_go)
        seen++;
    end
    if (seen < 2)
    begin
      $display("Timeout: the first two chunk_go pulses did not arrive");
      timeouts++;
    end
    strobe(build_instr(OPC_CONV, 0, 1, 2, 0, 0, 3, 2, 5, 'habc, 'hdef));
    wait_layer_done();
    layers++;
    assert (starts == starts_before + 1)
      else report_mismatch("conv_start count", starts_before + 1, starts);
  endtask

  ////////////////////
  // Array model answers each chunk_go after 1 to 8 cycles
  initial
  begin
    int   delay;
    logic pending;
    array_done = 1'b0;
    pending = 1'b0;
    delay = 0;
    forever
    begin
      @(negedge clk);
      array_done = 1'b0;
      if (chunk_go)
      begin
        pending = 1'b1;
        delay = rand_range(1, 8);
      end
      else if (pending)
      begin
        delay--;
        if (delay == 0)
        begin
          array_done = 1'b1;
          pending = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Reference model and per-cycle checks
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (conv_start)
      begin
        starts++;
        exp_ox_t = ceil_div(ref_ox(f_ix_log2, f_k, f_s, f_p), `CONV_POX);
        exp_oy_t = ceil_div(f_oy, `CONV_POY);
        exp_of_t = ceil_div(f_of, `CONV_POF);
        exp_chunks = exp_ox_t * exp_oy_t * exp_of_t;
        exp_nkk = (1 << f_nif_log2) * f_k * f_k;
        exp_mode = f_mode;
        exp_wadr = f_wbase * 16;
        exp_oadr = f_obase * 16;
        exp_ox = 0;
        exp_oy = 0;
        exp_of = 0;
        go_cnt = 0;
        wb_cnt = 0;
        assert (busy) else report_mismatch("busy", 1, int'(busy));
        assert (int'(mode) == exp_mode) else report_mismatch("mode", exp_mode, int'(mode));
      end
      if (chunk_go)
      begin
        assert (busy) else report_mismatch("busy", 1, int'(busy));
        assert (int'(mode) == exp_mode) else report_mismatch("mode", exp_mode, int'(mode));
        assert (int'(ox_idx) == exp_ox) else report_mismatch("ox_idx", exp_ox, int'(ox_idx));
        assert (int'(oy_idx) == exp_oy) else report_mismatch("oy_idx", exp_oy, int'(oy_idx));
        assert (int'(of_idx) == exp_of) else report_mismatch("of_idx", exp_of, int'(of_idx));
        assert (int'(bias_adr) == exp_of * `CONV_POF % 65536)
          else report_mismatch("bias_adr", exp_of * `CONV_POF % 65536, int'(bias_adr));
        assert (int'(weights_adr) == (exp_wadr + exp_of * `CONV_POF * exp_nkk) % 65536)
          else report_mismatch("weights_adr", (exp_wadr + exp_of * `CONV_POF * exp_nkk) % 65536,
                               int'(weights_adr));
        go_cnt++;
        // ox fastest, then oy, then of
        if (exp_ox + 1 < exp_ox_t)
          exp_ox++;
        else
        begin
          exp_ox = 0;
          if (exp_oy + 1 < exp_oy_t)
            exp_oy++;
          else
          begin
            exp_oy = 0;
            exp_of++;
          end
        end
      end
      if (wb_valid)
      begin
        assert (int'(wb_adr) == (exp_oadr + wb_cnt * `CONV_POX * `CONV_POY) % 65536)
          else report_mismatch("wb_adr", (exp_oadr + wb_cnt * `CONV_POX * `CONV_POY) % 65536,
                               int'(wb_adr));
        wb_cnt++;
        assert (int'(layer_done) == int'(wb_cnt == exp_chunks))
          else report_mismatch("layer_done", int'(wb_cnt == exp_chunks), int'(layer_done));
      end
      if (layer_done)
      begin
        assert (wb_valid) else report_mismatch("wb_valid", 1, int'(wb_valid));
        assert (!busy) else report_mismatch("busy", 0, int'(busy));
        assert (go_cnt == exp_chunks) else report_mismatch("chunk_go count", exp_chunks, go_cnt);
      end
    end
  end

  // Start only one cycle after an accepted CONV strobe
  start_after_strobe : assert property (@(posedge clk) disable iff (reset)
      (instr_valid && instr[3:0] == OPC_CONV && !busy) |=> conv_start)
    else report_mismatch("conv_start", 1, 0);
  no_start_otherwise : assert property (@(posedge clk) disable iff (reset)
      !(instr_valid && instr[3:0] == OPC_CONV && !busy) |=> !conv_start)
    else report_mismatch("conv_start", 0, 1);

  // Every array_done is accepted, since the model answers only in WAIT_DONE
  wb_after_done : assert property (@(posedge clk) disable iff (reset)
      array_done |=> wb_valid)
    else report_mismatch("wb_valid", 1, 0);
  no_wb_otherwise : assert property (@(posedge clk) disable iff (reset)
      !array_done |=> !wb_valid)
    else report_mismatch("wb_valid", 0, 1);

  ////////////////////
  // Main sequence
  initial
  begin
    instr = '0;
    instr_valid = 1'b0;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // NOP and POOL start nothing
    strobe(build_instr(OPC_NOP, 0, 3, 1, 1, 2, 5, 8, 20, 1, 2));
    strobe(build_instr(OPC_POOL, 1, 3, 2, 0, 1, 4, 4, 16, 3, 4));
    repeat (4) @(negedge clk);
    assert (starts == 0) else report_mismatch("conv_start count", 0, starts);
    assert (!busy) else report_mismatch("busy", 0, int'(busy));

    run_layer(1, 3, 1, 1, 2, 5, 8, 20, 'h010, 'h100);
    run_layer(0, 1, 2, 0, 0, 4, 3, 16, 'hfff, 'h7f0);
    repeat (6) random_layer();
    busy_strobe_test();
    run_layer(0, 3, 2, 1, 3, 6, 12, 33, 'h200, 'h0f0);
    finish_run();
  end

endmodule

// File: src.f
+incdir+rtl
rtl/conv_instr_pkg.sv
rtl/conv_layer_pkg.sv
rtl/conv_ifs.sv
rtl/conv_decoder.sv
rtl/conv_tile_sequencer.sv
rtl/conv_writeback_tracker.sv
rtl/conv_ctrl_top.sv
tb/conv_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module conv_ctrl_tb --Mdir obj_dir -o conv_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/conv_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0
